// ==== sources.f ====
source/dcache_pkg.sv
source/tag_data_bank.sv
source/lru_tracker.sv
source/way_select.sv
source/miss_control.sv
source/dcache_top.sv
verif/l2_memory_model.sv
verif/dcache_assert.sv
verif/dcache_tb.sv

// ==== verif/dcache_tb.sv ====
// Data cache testbench top with clock, reset, directed and random accesses and checking
`timescale 1ns/1ps
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_OPS   = 400;
    // About 430 accesses of at most 12 cycles each, with wide margin
    localparam int MAX_CYCLES   = 20000;

    logic       clk;
    logic       rst_n;
    core_req_t  req;
    logic       blocked;
    core_resp_t resp;
    l2_read_t   l2_rd;
    l2_block_t  l2_wr;
    l2_block_t  l2_fill;

    // Last stored word per address
    word_t       stored [addr_t];
    word_t       exp_q [$];
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          accept_cycle;
    int          resp_cycle;
    int          rd_count = 0;
    int          wr_count = 0;
    addr_t       last_wr_addr;
    addr_t       cur_addr;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;

    dcache_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .blocked (blocked),
        .resp    (resp),
        .l2_rd   (l2_rd),
        .l2_wr   (l2_wr),
        .l2_fill (l2_fill)
    );

    l2_memory_model i_l2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .l2_rd   (l2_rd),
        .l2_wr   (l2_wr),
        .l2_fill (l2_fill)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Same start pattern as the L2 memory
    function automatic word_t init_word(addr_t addr);
        return (word_t'(addr >> BYTE_OFF_W) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic word_t expected_word(addr_t addr);
        if (stored.exists(addr)) begin
            return stored[addr];
        end
        return init_word(addr);
    endfunction

    task automatic report_mismatch(string what, word_t got, word_t want);
        errors++;
        $display("FAIL %0t: %s got %h expected %h", $time, what, got, want);
    endtask

    task automatic report_error(string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic end_test(string name, int errors_before);
        tests++;
        $display("Test %0d %-12s finished, %0d errors", tests, name, errors - errors_before);
    endtask

    // Starts and ends at a rising edge with the cache idle
    task automatic issue_access(input logic is_store, input addr_t addr, input word_t data,
                                output logic missed);
        req <= '{valid: 1'b1, store: is_store, addr: addr, wdata: data};
        cur_addr = addr;
        if (is_store) begin
            stored[addr] = data;
        end else begin
            exp_q.push_back(expected_word(addr));
        end
        @(posedge clk);
        req.valid <= 1'b0;
        @(negedge clk);
        accept_cycle = cycle_cnt;
        missed       = blocked;
        while (blocked) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (!is_store && exp_q.size() != 0) begin
            report_error("load response missing");
            exp_q.delete();
        end else if (!is_store && !missed && resp_cycle != accept_cycle) begin
            report_error("hit load response not in the cycle after acceptance");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("Timeout: run stopped after %0d cycles", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

    // Response and write-back comparison
    always @(negedge clk) begin : compare
        word_t want;
        if (rst_n) begin
            if (l2_rd.valid) begin
                rd_count++;
                checks++;
                if (l2_rd.addr !== {cur_addr[31:4], 4'h0}) begin
                    report_mismatch("read address", l2_rd.addr, {cur_addr[31:4], 4'h0});
                end
            end
            if (l2_wr.valid) begin
                wr_count++;
                last_wr_addr = l2_wr.addr;
                for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
                    want = expected_word(l2_wr.addr + addr_t'(i * 4));
                    checks++;
                    if (l2_wr.block[i*WORD_W +: WORD_W] !== want) begin
                        report_mismatch("write-back word", l2_wr.block[i*WORD_W +: WORD_W],
                                        want);
                    end
                end
            end
            if (resp.valid) begin
                resp_cycle = cycle_cnt;
                if (exp_q.size() == 0) begin
                    report_error("response with no load outstanding");
                end else begin
                    want = exp_q.pop_front();
                    checks++;
                    if (resp.rdata !== want) begin
                        report_mismatch("load data", resp.rdata, want);
                    end
                end
            end
        end
    end

    initial begin
        logic        missed;
        addr_t       a;
        addr_t       first_addr;
        logic [31:0] r;
        int          rd_before;
        int          wr_before;
        int          errors_before;
        lcg_state = 32'h825315e6;
        rst_n     = 1'b0;
        req       = '0;
        cur_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        errors_before = errors;
        @(negedge clk);
        if (blocked !== 1'b0 || resp.valid !== 1'b0 || l2_rd.valid !== 1'b0
                || l2_wr.valid !== 1'b0) begin
            report_error("outputs not idle after reset");
        end
        @(posedge clk);
        end_test("reset", errors_before);

        // Cold miss, then the same word again as a hit
        errors_before = errors;
        for (int i = 0; i < 4; i++) begin
            a = 32'h0000_1000 + addr_t'(i) * 32'h44;
            issue_access(1'b0, a, '0, missed);
            if (!missed) begin
                report_error("cold load did not miss");
            end
            rd_before = rd_count;
            issue_access(1'b0, a, '0, missed);
            if (missed || rd_count != rd_before) begin
                report_error("repeated load was not a hit");
            end
        end
        end_test("cold_loads", errors_before);

        errors_before = errors;
        a = 32'h0000_1004;
        issue_access(1'b1, a, next_random(), missed);
        if (missed) begin
            report_error("store to a cached line missed");
        end
        issue_access(1'b0, a, '0, missed);
        a = 32'h0000_2008;
        issue_access(1'b1, a, next_random(), missed);
        if (!missed) begin
            report_error("store to an uncached line did not miss");
        end
        issue_access(1'b0, a, '0, missed);
        end_test("store_load", errors_before);

        // Five tags in set 9, the first one becomes the dirty victim
        errors_before = errors;
        first_addr    = 32'h0000_3090;
        wr_before     = wr_count;
        for (int t = 0; t < 5; t++) begin
            a = 32'h0000_3090 + addr_t'(t) * 32'h100 + addr_t'(t % 4) * 4;
            if (t == 4) begin
                if (wr_count != wr_before) begin
                    report_error("write-back while set 9 still had a free way");
                end
                wr_before = wr_count;
            end
            issue_access(1'b1, a, next_random(), missed);
        end
        if (wr_count != wr_before + 1) begin
            report_error("fifth store in set 9 wrote back no dirty line");
        end else if (last_wr_addr !== {first_addr[31:4], 4'h0}) begin
            report_mismatch("write-back address", last_wr_addr, {first_addr[31:4], 4'h0});
        end
        issue_access(1'b0, first_addr, '0, missed);
        if (!missed) begin
            report_error("reload of the evicted line did not miss");
        end
        end_test("eviction", errors_before);

        errors_before = errors;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_random();
            a = 32'h0000_4000 | ((r >> 8) & 32'h0000_07FC);
            issue_access(r[31], a, next_random(), missed);
        end
        end_test("random_mix", errors_before);

        errors += i_dut.i_assert.fail_count;
        $display("Summary: %0d tests, %0d values compared, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dcache_assert.sv ====
// Protocol assertions on the data cache ports, bound into dcache_top
`timescale 1ns/1ps
`default_nettype none

module dcache_assert
    import dcache_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       blocked,
    input wire core_resp_t resp,
    input wire l2_read_t   l2_rd,
    input wire l2_block_t  l2_wr
);

    int fail_count = 0;

    // One read request per miss
    rd_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) l2_rd.valid |=> !l2_rd.valid
    ) else begin
        fail_count++;
        $error("l2_rd.valid high for two consecutive cycles");
    end

    // Write-back only goes out alongside the read of the new line
    wr_with_rd: assert property (
        @(posedge clk) disable iff (!rst_n) l2_wr.valid |-> l2_rd.valid
    ) else begin
        fail_count++;
        $error("l2_wr.valid without l2_rd.valid");
    end

    resp_unblocked: assert property (
        @(posedge clk) disable iff (!rst_n) resp.valid |-> !blocked
    ) else begin
        fail_count++;
        $error("resp.valid while blocked");
    end

    reset_idle: assert property (
        @(posedge clk) $rose(rst_n) |-> !blocked && !resp.valid && !l2_rd.valid && !l2_wr.valid
    ) else begin
        fail_count++;
        $error("outputs not idle after reset");
    end

endmodule

bind dcache_top dcache_assert i_assert (.*);

`default_nettype wire

// ==== verif/l2_memory_model.sv ====
// Testbench L2 memory with fixed-latency block reads and write-back storage
`timescale 1ns/1ps
`default_nettype none

module l2_memory_model
    import dcache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire l2_read_t  l2_rd,
    input  wire l2_block_t l2_wr,
    output l2_block_t      l2_fill
);

    localparam int READ_LATENCY = 3;
    // 64 KiB of backing store covers every test address
    localparam int MEM_WORDS    = 16384;

    word_t                   mem [MEM_WORDS];
    logic [READ_LATENCY-1:0] rd_valid;
    addr_t                   rd_addr [READ_LATENCY];

    // Odd multiplier keeps every word address distinct
    function automatic word_t init_word(addr_t addr);
        return (word_t'(addr >> BYTE_OFF_W) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic int word_index(addr_t addr);
        return int'(addr[15:BYTE_OFF_W]);
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = init_word(addr_t'(i) << BYTE_OFF_W);
        end
    end

    // Read delay line and write-back capture
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= '0;
        end else begin
            rd_valid   <= {rd_valid[READ_LATENCY-2:0], l2_rd.valid};
            rd_addr[0] <= l2_rd.addr;
            for (int i = 1; i < READ_LATENCY; i++) begin
                rd_addr[i] <= rd_addr[i-1];
            end
            if (l2_wr.valid) begin
                for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
                    mem[word_index(l2_wr.addr) + i] <= l2_wr.block[i*WORD_W +: WORD_W];
                end
            end
        end
    end

    // Fill block read from the current memory contents
    always_comb begin
        l2_fill.valid = rd_valid[READ_LATENCY-1];
        l2_fill.addr  = rd_addr[READ_LATENCY-1];
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            l2_fill.block[i*WORD_W +: WORD_W] = mem[word_index(rd_addr[READ_LATENCY-1]) + i];
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_top.sv ====
// Blocking write-back 4-way data cache top level with banks, LRU, way select and miss control
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire core_req_t req,
    output logic           blocked,
    output core_resp_t     resp,
    output l2_read_t       l2_rd,
    output l2_block_t      l2_wr,
    input  wire l2_block_t l2_fill
);

    addr_t  lookup_addr;
    word_t  store_data;
    index_t index;
    tag_t   fill_tag;

    logic   [WAYS-1:0] line_valid;
    logic   [WAYS-1:0] line_dirty;
    tag_t   [WAYS-1:0] line_tag;
    block_t [WAYS-1:0] line_block;
    logic   [WAYS-1:0] way_fill_en;
    logic   [WAYS-1:0] way_store_en;

    logic   hit;
    way_t   hit_way;
    word_t  read_word;
    block_t merged_block;
    way_t   victim_way;
    logic   victim_dirty;
    addr_t  victim_addr;
    block_t victim_block;
    way_t   lru_way;
    way_t   fill_way;
    logic   fill_en;
    logic   store_en;
    logic   touch;

    assign index    = lookup_addr[BYTE_OFF_W + WORD_SEL_W +: INDEX_W];
    assign fill_tag = l2_fill.addr[ADDR_W-1 -: TAG_W];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        // Per-way enables from the selected way numbers
        assign way_fill_en[w]  = fill_en  && (fill_way == way_t'(w));
        assign way_store_en[w] = store_en && (hit_way == way_t'(w));

        tag_data_bank i_bank (
            .clk         (clk),
            .rst_n       (rst_n),
            .index       (index),
            .fill_en     (way_fill_en[w]),
            .fill_tag    (fill_tag),
            .fill_block  (l2_fill.block),
            .store_en    (way_store_en[w]),
            .store_block (merged_block),
            .line_valid  (line_valid[w]),
            .line_dirty  (line_dirty[w]),
            .line_tag    (line_tag[w]),
            .line_block  (line_block[w])
        );
    end

    lru_tracker i_lru (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (index),
        .touch     (touch),
        .touch_way (hit_way),
        .lru_way   (lru_way)
    );

    way_select i_way_select (
        .lookup_addr  (lookup_addr),
        .store_data   (store_data),
        .line_valid   (line_valid),
        .line_dirty   (line_dirty),
        .line_tag     (line_tag),
        .line_block   (line_block),
        .lru_way      (lru_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .read_word    (read_word),
        .merged_block (merged_block),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_block (victim_block)
    );

    miss_control i_miss_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .l2_fill      (l2_fill),
        .hit          (hit),
        .hit_way      (hit_way),
        .read_word    (read_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_block (victim_block),
        .blocked      (blocked),
        .lookup_addr  (lookup_addr),
        .store_data   (store_data),
        .fill_way     (fill_way),
        .fill_en      (fill_en),
        .store_en     (store_en),
        .touch        (touch),
        .resp         (resp),
        .l2_rd        (l2_rd),
        .l2_wr        (l2_wr)
    );

endmodule

`default_nettype wire

// ==== source/miss_control.sv ====
// Request acceptance, miss handling FSM with eviction, fill and replay, load response
`timescale 1ns/1ps
`default_nettype none

module miss_control
    import dcache_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire core_req_t req,
    input  wire l2_block_t l2_fill,
    input  wire logic      hit,
    input  wire way_t      hit_way,
    input  wire word_t     read_word,
    input  wire way_t      victim_way,
    input  wire logic      victim_dirty,
    input  wire addr_t     victim_addr,
    input  wire block_t    victim_block,
    output logic           blocked,
    output addr_t          lookup_addr,
    output word_t          store_data,
    output way_t           fill_way,
    output logic           fill_en,
    output logic           store_en,
    output logic           touch,
    output core_resp_t     resp,
    output l2_read_t       l2_rd,
    output l2_block_t      l2_wr
);

    typedef enum logic [1:0] {IDLE, MISS, WAIT_FILL, REPLAY} state_t;

    state_t    state_q;
    state_t    state_d;
    core_req_t req_q;
    way_t      fill_way_q;
    logic      accept;
    logic      cur_store;
    logic      serve;
    logic      resp_valid_q;
    word_t     resp_data_q;

    assign accept    = (state_q == IDLE) && req.valid;
    assign blocked   = (state_q != IDLE);

    // Live request while idle, the captured one during a miss
    assign lookup_addr = (state_q == IDLE) ? req.addr  : req_q.addr;
    assign store_data  = (state_q == IDLE) ? req.wdata : req_q.wdata;
    assign cur_store   = (state_q == IDLE) ? req.store : req_q.store;

    // Hit on a new request or on the replay after a fill
    assign serve    = (accept || state_q == REPLAY) && hit;
    assign touch    = serve;
    assign store_en = serve && cur_store;
    assign fill_en  = (state_q == WAIT_FILL) && l2_fill.valid;
    assign fill_way = fill_way_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (accept && !hit) state_d = MISS;
            MISS:      state_d = WAIT_FILL;
            WAIT_FILL: if (l2_fill.valid) state_d = REPLAY;
            REPLAY:    state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= IDLE;
            fill_way_q   <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= serve && !cur_store;
            if (accept && !hit) begin
                fill_way_q <= victim_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !hit) begin
            req_q <= req;
        end
        if (serve && !cur_store) begin
            resp_data_q <= read_word;
        end
    end

    always_comb begin
        resp.valid = resp_valid_q;
        resp.rdata = resp_data_q;
    end

    // Both L2 requests go out in the single MISS cycle
    always_comb begin
        l2_rd.valid = (state_q == MISS);
        l2_rd.addr  = {req_q.addr[ADDR_W-1:WORD_SEL_W + BYTE_OFF_W],
                       {(WORD_SEL_W + BYTE_OFF_W){1'b0}}};
        l2_wr.valid = (state_q == MISS) && victim_dirty;
        l2_wr.addr  = victim_addr;
        l2_wr.block = victim_block;
    end

endmodule

`default_nettype wire

// ==== source/way_select.sv ====
// Hit detection, word read, store merge and victim choice across all ways
`timescale 1ns/1ps
`default_nettype none

module way_select
    import dcache_pkg::*;
(
    input  wire addr_t                 lookup_addr,
    input  wire word_t                 store_data,
    input  wire logic   [WAYS-1:0]     line_valid,
    input  wire logic   [WAYS-1:0]     line_dirty,
    input  wire tag_t   [WAYS-1:0]     line_tag,
    input  wire block_t [WAYS-1:0]     line_block,
    input  wire way_t                  lru_way,
    output logic                       hit,
    output way_t                       hit_way,
    output word_t                      read_word,
    output block_t                     merged_block,
    output way_t                       victim_way,
    output logic                       victim_dirty,
    output addr_t                      victim_addr,
    output block_t                     victim_block
);

    tag_t      lookup_tag;
    index_t    lookup_index;
    word_sel_t word_sel;
    block_t    hit_block;

    assign word_sel     = lookup_addr[BYTE_OFF_W +: WORD_SEL_W];
    assign lookup_index = lookup_addr[BYTE_OFF_W + WORD_SEL_W +: INDEX_W];
    assign lookup_tag   = lookup_addr[ADDR_W-1 -: TAG_W];

    // Tag compare on every valid way
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        hit_block = line_block[0];
        for (int w = 0; w < WAYS; w++) begin
            if (line_valid[w] && line_tag[w] == lookup_tag) begin
                hit       = 1'b1;
                hit_way   = way_t'(w);
                hit_block = line_block[w];
            end
        end
    end

    // Word pick and store merge on the hit line
    always_comb begin
        read_word    = hit_block[WORD_W-1:0];
        merged_block = hit_block;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            if (word_sel == word_sel_t'(i)) begin
                read_word                      = hit_block[i*WORD_W +: WORD_W];
                merged_block[i*WORD_W +: WORD_W] = store_data;
            end
        end
    end

    // Lowest invalid way first, LRU way once the set is full
    always_comb begin
        logic found_invalid;
        found_invalid = 1'b0;
        victim_way    = lru_way;
        for (int w = 0; w < WAYS; w++) begin
            if (!line_valid[w] && !found_invalid) begin
                found_invalid = 1'b1;
                victim_way    = way_t'(w);
            end
        end
    end

    assign victim_dirty = line_valid[victim_way] & line_dirty[victim_way];
    assign victim_block = line_block[victim_way];
    // Block address rebuilt from the stored tag
    assign victim_addr  = {line_tag[victim_way], lookup_index,
                           {(WORD_SEL_W + BYTE_OFF_W){1'b0}}};

endmodule

`default_nettype wire

// ==== source/lru_tracker.sv ====
// True-LRU age tracking per set and least-recently-used way lookup
`timescale 1ns/1ps
`default_nettype none

module lru_tracker
    import dcache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire index_t index,
    input  wire logic   touch,
    input  wire way_t   touch_way,
    output way_t        lru_way
);

    // Age 0 is most recent, WAYS-1 is the oldest
    way_t age_q [SETS][WAYS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // Way 0 starts as the oldest
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age_q[s][w] <= way_t'(WAYS - 1 - w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == touch_way) begin
                    age_q[index][w] <= '0;
                end else if (age_q[index][w] < age_q[index][touch_way]) begin
                    // Younger than the touched way, so it ages by one
                    age_q[index][w] <= age_q[index][w] + way_t'(1);
                end
            end
        end
    end

    // Ages of a set are a permutation, exactly one way is the oldest
    always_comb begin
        lru_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (age_q[index][w] == way_t'(WAYS - 1)) begin
                lru_way = way_t'(w);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/tag_data_bank.sv ====
// One cache way: tag and block arrays plus per-line valid and dirty bits
`timescale 1ns/1ps
`default_nettype none

module tag_data_bank
    import dcache_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_n,
    input  wire index_t index,
    input  wire logic   fill_en,
    input  wire tag_t   fill_tag,
    input  wire block_t fill_block,
    input  wire logic   store_en,
    input  wire block_t store_block,
    output logic        line_valid,
    output logic        line_dirty,
    output tag_t        line_tag,
    output block_t      line_block
);

    tag_t   tag_mem   [SETS];
    block_t block_mem [SETS];
    logic [SETS-1:0] valid_bits;
    logic [SETS-1:0] dirty_bits;

    // Storage arrays
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index]   <= fill_tag;
            block_mem[index] <= fill_block;
        end else if (store_en) begin
            block_mem[index] <= store_block;
        end
    end

    // Line state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_en) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
        end else if (store_en) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    // Asynchronous read of the addressed line
    assign line_valid = valid_bits[index];
    assign line_dirty = dirty_bits[index];
    assign line_tag   = tag_mem[index];
    assign line_block = block_mem[index];

endmodule

`default_nettype wire

// ==== source/dcache_pkg.sv ====
// Cache geometry constants, vector types and port structs for the data cache
`default_nettype none

package dcache_pkg;

    // Geometry
    localparam int ADDR_W          = 32;
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
    localparam int WAYS            = 4;
    localparam int SETS            = 16;

    // Address split: tag | index | word select | byte offset
    localparam int BYTE_OFF_W = 2;
    localparam int WORD_SEL_W = $clog2(WORDS_PER_BLOCK);
    localparam int INDEX_W    = $clog2(SETS);
    localparam int TAG_W      = ADDR_W - INDEX_W - WORD_SEL_W - BYTE_OFF_W;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [BLOCK_W-1:0]      block_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [INDEX_W-1:0]      index_t;
    typedef logic [WORD_SEL_W-1:0]   word_sel_t;
    typedef logic [$clog2(WAYS)-1:0] way_t;

    // Core request, one aligned word per access
    typedef struct packed {
        logic  valid;
        logic  store;
        addr_t addr;
        word_t wdata;
    } core_req_t;

    // Load data back to the core
    typedef struct packed {
        logic  valid;
        word_t rdata;
    } core_resp_t;

    // Block read request towards L2
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } l2_read_t;

    // Full block transfer, write-back out or fill in
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        block_t block;
    } l2_block_t;

endpackage

`default_nettype wire
